/* src/fpu_pkg.sv */
// FPU package with the FP32 widths, operation codes, flag and class positions and payloads.
`default_nettype none

package fpu_pkg;

  typedef logic [31:0] fp32_t;
  typedef logic [5:0]  tag_t;
  // Flags in the order NV, DZ, OF, UF, NX from bit 4 down to bit 0.
  typedef logic [4:0]  status_t;
  typedef logic [2:0]  variant_t;

  localparam int unsigned STATUS_NV = 4;

  typedef enum logic [1:0] {
    OP_SGNJ,
    OP_MINMAX,
    OP_CMP,
    OP_CLASS
  } op_e;

  localparam fp32_t CANON_NAN = 32'h7FC0_0000;

  // One-hot bit positions of the classify result.
  localparam int unsigned CLASS_NEG_INF     = 0;
  localparam int unsigned CLASS_NEG_NORM    = 1;
  localparam int unsigned CLASS_NEG_SUBNORM = 2;
  localparam int unsigned CLASS_NEG_ZERO    = 3;
  localparam int unsigned CLASS_POS_ZERO    = 4;
  localparam int unsigned CLASS_POS_SUBNORM = 5;
  localparam int unsigned CLASS_POS_NORM    = 6;
  localparam int unsigned CLASS_POS_INF     = 7;
  localparam int unsigned CLASS_SNAN        = 8;
  localparam int unsigned CLASS_QNAN        = 9;

  typedef struct packed {
    fp32_t    a;
    fp32_t    b;
    op_e      op;
    variant_t variant;
    tag_t     tag;
  } fpu_req_t;

  typedef struct packed {
    fp32_t   result;
    status_t status;
    tag_t    tag;
  } fpu_rsp_t;

endpackage

`default_nettype wire

/* src/fpu_if.sv */
// Request and response handshake interfaces between the spill registers and the FPU.
`timescale 1ns/10ps
`default_nettype none

interface fpu_req_if;

  logic                valid;
  logic                ready;
  fpu_pkg::fpu_req_t   data;

  modport source (
    output valid,
    output data,
    input  ready
  );

  modport sink (
    input  valid,
    input  data,
    output ready
  );

endinterface

interface fpu_rsp_if;

  logic                valid;
  logic                ready;
  fpu_pkg::fpu_rsp_t   data;

  modport source (
    output valid,
    output data,
    input  ready
  );

  modport sink (
    input  valid,
    input  data,
    output ready
  );

endinterface

`default_nettype wire

/* src/spill_register.sv */
// Spill register, a two-slot elastic buffer that cuts both handshake paths.
`timescale 1ns/10ps
`default_nettype none

module spill_register #(
  parameter type T      = logic,
  parameter bit  Bypass = 1'b0
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  if (Bypass) begin : gen_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_spill
    T     a_data_q, b_data_q;
    logic a_full_q, b_full_q;
    logic a_fill, a_drain, b_fill, b_drain;

    // Slot A takes new data, slot B catches it when the output stalls.
    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q;
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill || a_drain) begin
          a_full_q <= a_fill;
        end
        if (b_fill || b_drain) begin
          b_full_q <= b_fill;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    // Slot B always holds the older item.
    assign valid_o = a_full_q || b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;
    assign ready_o = !a_full_q || !b_full_q;
  end

endmodule

`default_nettype wire

/* src/fpu_noncomp.sv */
// FP32 non-computational unit for sign injection, min/max, compare and classify.
`timescale 1ns/10ps
`default_nettype none

module fpu_noncomp #(
  parameter int unsigned NumPipeRegs = 1
) (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            ftz_i,
  fpu_req_if.sink         req,
  fpu_rsp_if.source       rsp
);

  function automatic logic [9:0] fp_class(fpu_pkg::fp32_t x);
    logic [9:0] cls;
    logic       exp_zero;
    logic       exp_ones;
    logic       man_zero;
    cls      = '0;
    exp_zero = (x[30:23] == 8'h00);
    exp_ones = (x[30:23] == 8'hFF);
    man_zero = (x[22:0] == 23'd0);
    if (exp_ones && !man_zero) begin
      cls[x[22] ? fpu_pkg::CLASS_QNAN : fpu_pkg::CLASS_SNAN] = 1'b1;
    end else if (exp_ones) begin
      cls[x[31] ? fpu_pkg::CLASS_NEG_INF : fpu_pkg::CLASS_POS_INF] = 1'b1;
    end else if (exp_zero && man_zero) begin
      cls[x[31] ? fpu_pkg::CLASS_NEG_ZERO : fpu_pkg::CLASS_POS_ZERO] = 1'b1;
    end else if (exp_zero) begin
      cls[x[31] ? fpu_pkg::CLASS_NEG_SUBNORM : fpu_pkg::CLASS_POS_SUBNORM] = 1'b1;
    end else begin
      cls[x[31] ? fpu_pkg::CLASS_NEG_NORM : fpu_pkg::CLASS_POS_NORM] = 1'b1;
    end
    return cls;
  endfunction

  fpu_pkg::fp32_t   a, b;
  fpu_pkg::fp32_t   fa, fb;
  logic [9:0]       cls_a, cls_b;
  logic             nan_a, nan_b, snan_any;
  logic             lt_tot, lt, eq, both_zero;
  fpu_pkg::fpu_rsp_t rsp_d;

  logic [NumPipeRegs-1:0] valid_q;
  fpu_pkg::fpu_rsp_t      data_q [NumPipeRegs];
  logic                   advance;

  assign a     = req.data.a;
  assign b     = req.data.b;
  assign cls_a = fp_class(a);
  assign cls_b = fp_class(b);

  assign nan_a    = cls_a[fpu_pkg::CLASS_SNAN] || cls_a[fpu_pkg::CLASS_QNAN];
  assign nan_b    = cls_b[fpu_pkg::CLASS_SNAN] || cls_b[fpu_pkg::CLASS_QNAN];
  assign snan_any = cls_a[fpu_pkg::CLASS_SNAN] || cls_b[fpu_pkg::CLASS_SNAN];

  // Subnormals become signed zeros for min/max and compare.
  assign fa = (ftz_i && (cls_a[fpu_pkg::CLASS_NEG_SUBNORM] || cls_a[fpu_pkg::CLASS_POS_SUBNORM]))
            ? {a[31], 31'd0} : a;
  assign fb = (ftz_i && (cls_b[fpu_pkg::CLASS_NEG_SUBNORM] || cls_b[fpu_pkg::CLASS_POS_SUBNORM]))
            ? {b[31], 31'd0} : b;

  // Total order with -0 below +0; the compares then mask the zero case.
  assign lt_tot    = (fa[31] != fb[31]) ? fa[31]
                   : (fa[31] ? (fa[30:0] > fb[30:0]) : (fa[30:0] < fb[30:0]));
  assign both_zero = (fa[30:0] == 31'd0) && (fb[30:0] == 31'd0);
  assign lt        = lt_tot && !both_zero;
  assign eq        = (fa == fb) || both_zero;

  always_comb begin
    rsp_d.result = '0;
    rsp_d.status = '0;
    rsp_d.tag    = req.data.tag;
    case (req.data.op)
      fpu_pkg::OP_SGNJ: begin
        case (req.data.variant)
          3'd0:    rsp_d.result = {b[31], a[30:0]};
          3'd1:    rsp_d.result = {~b[31], a[30:0]};
          default: rsp_d.result = {a[31] ^ b[31], a[30:0]};
        endcase
      end
      fpu_pkg::OP_MINMAX: begin
        rsp_d.status[fpu_pkg::STATUS_NV] = snan_any;
        if (nan_a && nan_b) begin
          rsp_d.result = fpu_pkg::CANON_NAN;
        end else if (nan_a) begin
          rsp_d.result = fb;
        end else if (nan_b) begin
          rsp_d.result = fa;
        end else if (req.data.variant[0]) begin
          rsp_d.result = lt_tot ? fb : fa;
        end else begin
          rsp_d.result = lt_tot ? fa : fb;
        end
      end
      fpu_pkg::OP_CMP: begin
        case (req.data.variant)
          3'd0: begin
            rsp_d.result[0]                  = !(nan_a || nan_b) && (lt || eq);
            rsp_d.status[fpu_pkg::STATUS_NV] = nan_a || nan_b;
          end
          3'd1: begin
            rsp_d.result[0]                  = !(nan_a || nan_b) && lt;
            rsp_d.status[fpu_pkg::STATUS_NV] = nan_a || nan_b;
          end
          default: begin
            rsp_d.result[0]                  = !(nan_a || nan_b) && eq;
            rsp_d.status[fpu_pkg::STATUS_NV] = snan_any;
          end
        endcase
      end
      default: rsp_d.result = {22'd0, cls_a};
    endcase
  end

  // The whole pipe moves together unless the last stage is stuck.
  assign advance   = !valid_q[NumPipeRegs-1] || rsp.ready;
  assign req.ready = advance;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
    end else if (advance) begin
      valid_q[0] <= req.valid;
      for (int unsigned i = 1; i < NumPipeRegs; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      data_q[0] <= rsp_d;
      for (int unsigned i = 1; i < NumPipeRegs; i++) begin
        data_q[i] <= data_q[i-1];
      end
    end
  end

  assign rsp.valid = valid_q[NumPipeRegs-1];
  assign rsp.data  = data_q[NumPipeRegs-1];

endmodule

`default_nettype wire

/* src/fpu_csr.sv */
// FPU control registers with the flush-to-zero enable and the sticky exception flags.
`timescale 1ns/10ps
`default_nettype none

module fpu_csr (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              ftz_we_i,
  input  logic              ftz_wdata_i,
  input  logic              fflags_clear_i,
  input  logic              rsp_valid_i,
  input  logic              rsp_ready_i,
  input  fpu_pkg::status_t  rsp_status_i,
  output logic              ftz_o,
  output fpu_pkg::status_t  fflags_o
);

  logic             ftz_q;
  fpu_pkg::status_t fflags_q;
  logic             rsp_fire;

  assign rsp_fire = rsp_valid_i && rsp_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ftz_q    <= 1'b0;
      fflags_q <= '0;
    end else begin
      if (ftz_we_i) begin
        ftz_q <= ftz_wdata_i;
      end
      // Clear wins over a retiring result.
      if (fflags_clear_i) begin
        fflags_q <= '0;
      end else if (rsp_fire) begin
        fflags_q <= fflags_q | rsp_status_i;
      end
    end
  end

  assign ftz_o    = ftz_q;
  assign fflags_o = fflags_q;

endmodule

`default_nettype wire

/* src/fpu_top.sv */
// FPU slice top level joining the spill registers, the non-computational unit and the CSRs.
`timescale 1ns/10ps
`default_nettype none

module fpu_top #(
  parameter int unsigned NumPipeRegs = 2,
  parameter bit          SpillBypass = 1'b0
) (
  input  logic              clk_i,
  input  logic              reset_i,
  // Request side.
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  fpu_pkg::fp32_t    op_a_i,
  input  fpu_pkg::fp32_t    op_b_i,
  input  fpu_pkg::op_e      op_i,
  input  fpu_pkg::variant_t variant_i,
  input  fpu_pkg::tag_t     tag_i,
  // Response side.
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output fpu_pkg::fp32_t    result_o,
  output fpu_pkg::status_t  status_o,
  output fpu_pkg::tag_t     tag_o,
  // Control registers.
  input  logic              ftz_we_i,
  input  logic              ftz_wdata_i,
  input  logic              fflags_clear_i,
  output fpu_pkg::status_t  fflags_o
);

  fpu_pkg::fpu_req_t fpu_in;
  fpu_pkg::fpu_rsp_t fpu_out;
  logic              ftz;

  fpu_req_if req_if ();
  fpu_rsp_if rsp_if ();

  assign fpu_in = '{a: op_a_i, b: op_b_i, op: op_i, variant: variant_i, tag: tag_i};

  spill_register #(
    .T      ( fpu_pkg::fpu_req_t ),
    .Bypass ( SpillBypass        )
  ) i_spill_register_in (
    .clk_i   ( clk_i        ),
    .reset_i ( reset_i      ),
    .valid_i ( in_valid_i   ),
    .ready_o ( in_ready_o   ),
    .data_i  ( fpu_in       ),
    .valid_o ( req_if.valid ),
    .ready_i ( req_if.ready ),
    .data_o  ( req_if.data  )
  );

  fpu_noncomp #(
    .NumPipeRegs ( NumPipeRegs )
  ) i_fpu_noncomp (
    .clk_i   ( clk_i   ),
    .reset_i ( reset_i ),
    .ftz_i   ( ftz     ),
    .req     ( req_if  ),
    .rsp     ( rsp_if  )
  );

  spill_register #(
    .T      ( fpu_pkg::fpu_rsp_t ),
    .Bypass ( SpillBypass        )
  ) i_spill_register_out (
    .clk_i   ( clk_i        ),
    .reset_i ( reset_i      ),
    .valid_i ( rsp_if.valid ),
    .ready_o ( rsp_if.ready ),
    .data_i  ( rsp_if.data  ),
    .valid_o ( out_valid_o  ),
    .ready_i ( out_ready_i  ),
    .data_o  ( fpu_out      )
  );

  fpu_csr i_fpu_csr (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .ftz_we_i       ( ftz_we_i       ),
    .ftz_wdata_i    ( ftz_wdata_i    ),
    .fflags_clear_i ( fflags_clear_i ),
    .rsp_valid_i    ( out_valid_o    ),
    .rsp_ready_i    ( out_ready_i    ),
    .rsp_status_i   ( status_o       ),
    .ftz_o          ( ftz            ),
    .fflags_o       ( fflags_o       )
  );

  assign result_o = fpu_out.result;
  assign status_o = fpu_out.status;
  assign tag_o    = fpu_out.tag;

endmodule

`default_nettype wire

/* include/tb_fpu_ref.svh */
// Reference model of the FP32 non-computational operations, their classes and flags.
`ifndef TB_FPU_REF_SVH
`define TB_FPU_REF_SVH

function automatic logic is_nan(input fpu_pkg::fp32_t x);
  return (x[30:23] == 8'hFF) && (x[22:0] != 23'd0);
endfunction

function automatic logic is_snan(input fpu_pkg::fp32_t x);
  return is_nan(x) && !x[22];
endfunction

function automatic logic [9:0] expected_class(input fpu_pkg::fp32_t x);
  logic [9:0] cls;
  cls = '0;
  if (is_nan(x)) begin
    cls[x[22] ? fpu_pkg::CLASS_QNAN : fpu_pkg::CLASS_SNAN] = 1'b1;
  end else if (x[30:0] == 31'h7F80_0000) begin
    cls[x[31] ? fpu_pkg::CLASS_NEG_INF : fpu_pkg::CLASS_POS_INF] = 1'b1;
  end else if (x[30:0] == 31'd0) begin
    cls[x[31] ? fpu_pkg::CLASS_NEG_ZERO : fpu_pkg::CLASS_POS_ZERO] = 1'b1;
  end else if (x[30:23] == 8'h00) begin
    cls[x[31] ? fpu_pkg::CLASS_NEG_SUBNORM : fpu_pkg::CLASS_POS_SUBNORM] = 1'b1;
  end else begin
    cls[x[31] ? fpu_pkg::CLASS_NEG_NORM : fpu_pkg::CLASS_POS_NORM] = 1'b1;
  end
  return cls;
endfunction

// Subnormals turn into a zero of the same sign.
function automatic fpu_pkg::fp32_t flushed(input fpu_pkg::fp32_t x, input logic ftz);
  if (ftz && (x[30:23] == 8'h00)) begin
    return {x[31], 31'd0};
  end
  return x;
endfunction

// Monotonic key over all non-NaN values, with -0 just below +0.
function automatic logic [31:0] order_key(input fpu_pkg::fp32_t x);
  return x[31] ? ~x : {1'b1, x[30:0]};
endfunction

function automatic logic both_zero(input fpu_pkg::fp32_t a, input fpu_pkg::fp32_t b);
  return (a[30:0] == 31'd0) && (b[30:0] == 31'd0);
endfunction

function automatic fpu_pkg::fp32_t sign_injected(input fpu_pkg::fp32_t a,
                                                 input fpu_pkg::fp32_t b,
                                                 input fpu_pkg::variant_t variant);
  case (variant)
    3'd0:    return {b[31], a[30:0]};
    3'd1:    return {!b[31], a[30:0]};
    default: return {a[31] ^ b[31], a[30:0]};
  endcase
endfunction

function automatic fpu_pkg::fpu_rsp_t expected_response(input fpu_pkg::fp32_t a,
                                                        input fpu_pkg::fp32_t b,
                                                        input fpu_pkg::op_e op,
                                                        input fpu_pkg::variant_t variant,
                                                        input fpu_pkg::tag_t tag,
                                                        input logic ftz);
  fpu_pkg::fpu_rsp_t rsp;
  fpu_pkg::fp32_t    fa;
  fpu_pkg::fp32_t    fb;
  logic              any_nan;
  logic              less;
  logic              equal;
  fa         = flushed(a, ftz);
  fb         = flushed(b, ftz);
  any_nan    = is_nan(a) || is_nan(b);
  less       = (order_key(fa) < order_key(fb)) && !both_zero(fa, fb);
  equal      = (fa == fb) || both_zero(fa, fb);
  rsp.result = '0;
  rsp.status = '0;
  rsp.tag    = tag;
  case (op)
    fpu_pkg::OP_SGNJ: rsp.result = sign_injected(a, b, variant);
    fpu_pkg::OP_MINMAX: begin
      rsp.status[fpu_pkg::STATUS_NV] = is_snan(a) || is_snan(b);
      if (is_nan(a) && is_nan(b)) begin
        rsp.result = fpu_pkg::CANON_NAN;
      end else if (is_nan(a)) begin
        rsp.result = fb;
      end else if (is_nan(b)) begin
        rsp.result = fa;
      end else if (variant == 3'd1) begin
        rsp.result = (order_key(fa) > order_key(fb)) ? fa : fb;
      end else begin
        rsp.result = (order_key(fa) < order_key(fb)) ? fa : fb;
      end
    end
    fpu_pkg::OP_CMP: begin
      case (variant)
        3'd0: begin
          rsp.result[0]                  = !any_nan && (less || equal);
          rsp.status[fpu_pkg::STATUS_NV] = any_nan;
        end
        3'd1: begin
          rsp.result[0]                  = !any_nan && less;
          rsp.status[fpu_pkg::STATUS_NV] = any_nan;
        end
        default: begin
          rsp.result[0]                  = !any_nan && equal;
          rsp.status[fpu_pkg::STATUS_NV] = is_snan(a) || is_snan(b);
        end
      endcase
    end
    default: rsp.result = {22'd0, expected_class(a)};
  endcase
  return rsp;
endfunction

`endif

/* bench/tb_fpu_top.sv */
// Testbench for the FPU slice with latency, special-value, random, flush-to-zero and flag tests.
`timescale 1ns/10ps
`default_nettype none

module tb_fpu_top;

  `include "tb_fpu_ref.svh"

  localparam int unsigned TIMEOUT_CYCLES = 4000;
  localparam int unsigned RANDOM_COUNT   = 200;
  localparam int unsigned SPECIAL_COUNT  = 10;

  logic              clk_i;
  logic              reset_i;
  logic              in_valid_i;
  logic              in_ready_o;
  fpu_pkg::fp32_t    op_a_i;
  fpu_pkg::fp32_t    op_b_i;
  fpu_pkg::op_e      op_i;
  fpu_pkg::variant_t variant_i;
  fpu_pkg::tag_t     tag_i;
  logic              out_valid_o;
  logic              out_ready_i;
  fpu_pkg::fp32_t    result_o;
  fpu_pkg::status_t  status_o;
  fpu_pkg::tag_t     tag_o;
  logic              ftz_we_i;
  logic              ftz_wdata_i;
  logic              fflags_clear_i;
  fpu_pkg::status_t  fflags_o;

  fpu_pkg::fpu_rsp_t expected_q [$];
  fpu_pkg::fp32_t    special_values [SPECIAL_COUNT];
  logic [31:0]       lfsr_state;
  logic              ftz_model;
  fpu_pkg::status_t  fflags_model;
  logic              random_ready;
  fpu_pkg::tag_t     next_tag;
  int unsigned       error_count;
  int unsigned       check_count;
  int unsigned       sent_count;
  int unsigned       received_count;
  int unsigned       cycle_count;

  fpu_top i_fpu_top (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .in_valid_i     ( in_valid_i     ),
    .in_ready_o     ( in_ready_o     ),
    .op_a_i         ( op_a_i         ),
    .op_b_i         ( op_b_i         ),
    .op_i           ( op_i           ),
    .variant_i      ( variant_i      ),
    .tag_i          ( tag_i          ),
    .out_valid_o    ( out_valid_o    ),
    .out_ready_i    ( out_ready_i    ),
    .result_o       ( result_o       ),
    .status_o       ( status_o       ),
    .tag_o          ( tag_o          ),
    .ftz_we_i       ( ftz_we_i       ),
    .ftz_wdata_i    ( ftz_wdata_i    ),
    .fflags_clear_i ( fflags_clear_i ),
    .fflags_o       ( fflags_o       )
  );

  always #10 clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [31:0] expected_value,
                             input logic [31:0] actual_value);
    check_count++;
    if (expected_value !== actual_value) begin
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected_value, actual_value);
      error_count++;
    end
  endtask

  // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit.
  function automatic logic [31:0] lfsr_bits(input int unsigned count);
    logic [31:0] value;
    logic        feedback;
    value = '0;
    for (int unsigned i = 0; i < count; i++) begin
      feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], feedback};
      value      = {value[30:0], feedback};
    end
    return value;
  endfunction

  function automatic fpu_pkg::fp32_t pick_operand();
    logic [31:0] bits;
    bits = lfsr_bits(2);
    if (bits[1:0] == 2'd0) begin
      bits = lfsr_bits(4);
      return special_values[bits[3:0] % SPECIAL_COUNT];
    end
    return lfsr_bits(32);
  endfunction

  function automatic fpu_pkg::variant_t pick_variant(input fpu_pkg::op_e op);
    logic [31:0] bits;
    bits = '0;
    if (op == fpu_pkg::OP_SGNJ || op == fpu_pkg::OP_CMP) begin
      bits = lfsr_bits(2) % 3;
    end else if (op == fpu_pkg::OP_MINMAX) begin
      bits = lfsr_bits(1);
    end
    return bits[2:0];
  endfunction

  // Output transfers retire in order against the expected queue.
  always @(posedge clk_i) begin : collect_responses
    fpu_pkg::fpu_rsp_t expected;
    if (!reset_i && out_valid_o && out_ready_i) begin
      received_count++;
      if (expected_q.size() == 0) begin
        $display("Unexpected response with tag %0d at %0t, nothing was outstanding",
                 tag_o, $time);
        error_count++;
      end else begin
        expected = expected_q.pop_front();
        check_value("result_o", expected.result, result_o);
        check_value("status_o", 32'(expected.status), 32'(status_o));
        check_value("tag_o", 32'(expected.tag), 32'(tag_o));
        fflags_model = fflags_model | expected.status;
      end
    end
  end

  always @(negedge clk_i) begin : drive_back_pressure
    logic [31:0] bits;
    if (random_ready) begin
      bits        = lfsr_bits(1);
      out_ready_i = bits[0];
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
      $display("%0d checks, %0d errors", check_count, error_count);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // Called just after a falling edge and returns at the falling edge after the transfer.
  task automatic send_request(input fpu_pkg::fp32_t a, input fpu_pkg::fp32_t b,
                              input fpu_pkg::op_e op, input fpu_pkg::variant_t variant);
    logic accepted;
    accepted   = 1'b0;
    op_a_i     = a;
    op_b_i     = b;
    op_i       = op;
    variant_i  = variant;
    tag_i      = next_tag;
    in_valid_i = 1'b1;
    expected_q.push_back(expected_response(a, b, op, variant, next_tag, ftz_model));
    next_tag++;
    sent_count++;
    while (!accepted) begin
      accepted = in_ready_o;
      @(negedge clk_i);
    end
    in_valid_i = 1'b0;
  endtask

  task automatic wait_for_drain();
    while (expected_q.size() != 0) begin
      @(negedge clk_i);
    end
  endtask

  task automatic write_ftz(input logic value);
    ftz_we_i    = 1'b1;
    ftz_wdata_i = value;
    @(negedge clk_i);
    ftz_we_i    = 1'b0;
    ftz_model   = value;
  endtask

  task automatic clear_flags();
    fflags_clear_i = 1'b1;
    @(negedge clk_i);
    fflags_clear_i = 1'b0;
    fflags_model   = '0;
  endtask

  task automatic latency_after_reset();
    int unsigned   latency;
    fpu_pkg::tag_t sent_tag;
    check_value("out_valid_o", 32'd0, 32'(out_valid_o));
    check_value("in_ready_o", 32'd1, 32'(in_ready_o));
    check_value("fflags_o", 32'd0, 32'(fflags_o));
    sent_tag = next_tag;
    send_request(32'h3F80_0000, 32'h0000_0000, fpu_pkg::OP_CLASS, 3'd0);
    latency = 1;
    while (!out_valid_o) begin
      @(negedge clk_i);
      latency++;
    end
    check_value("latency", 32'd4, latency);
    check_value("result_o", 32'd1 << fpu_pkg::CLASS_POS_NORM, result_o);
    check_value("status_o", 32'd0, 32'(status_o));
    check_value("tag_o", 32'(sent_tag), 32'(tag_o));
    wait_for_drain();
  endtask

  task automatic special_value_sweep();
    for (int unsigned i = 0; i < SPECIAL_COUNT; i++) begin
      for (int unsigned j = 0; j < SPECIAL_COUNT; j++) begin
        for (int unsigned v = 0; v < 3; v++) begin
          send_request(special_values[i], special_values[j], fpu_pkg::OP_SGNJ, 3'(v));
          send_request(special_values[i], special_values[j], fpu_pkg::OP_CMP, 3'(v));
        end
        send_request(special_values[i], special_values[j], fpu_pkg::OP_MINMAX, 3'd0);
        send_request(special_values[i], special_values[j], fpu_pkg::OP_MINMAX, 3'd1);
      end
      send_request(special_values[i], 32'h0000_0000, fpu_pkg::OP_CLASS, 3'd0);
    end
    wait_for_drain();
  endtask

  task automatic random_traffic();
    fpu_pkg::fp32_t    a_list [RANDOM_COUNT];
    fpu_pkg::fp32_t    b_list [RANDOM_COUNT];
    fpu_pkg::op_e      op_list [RANDOM_COUNT];
    fpu_pkg::variant_t variant_list [RANDOM_COUNT];
    logic [31:0]       bits;
    for (int unsigned n = 0; n < RANDOM_COUNT; n++) begin
      a_list[n]       = pick_operand();
      b_list[n]       = pick_operand();
      bits            = lfsr_bits(2);
      op_list[n]      = fpu_pkg::op_e'(bits[1:0]);
      variant_list[n] = pick_variant(op_list[n]);
    end
    // Back-pressure starts and stops between edges.
    @(posedge clk_i);
    random_ready = 1'b1;
    @(negedge clk_i);
    for (int unsigned n = 0; n < RANDOM_COUNT; n++) begin
      send_request(a_list[n], b_list[n], op_list[n], variant_list[n]);
    end
    wait_for_drain();
    @(posedge clk_i);
    random_ready = 1'b0;
    @(negedge clk_i);
    out_ready_i = 1'b1;
    check_value("fflags_o", 32'(fflags_model), 32'(fflags_o));
  endtask

  task automatic subnormal_cases();
    send_request(32'h0000_0001, 32'h0000_0000, fpu_pkg::OP_MINMAX, 3'd1);
    send_request(32'h807F_FFFF, 32'h0000_0001, fpu_pkg::OP_MINMAX, 3'd0);
    send_request(32'h7FC0_0000, 32'h807F_FFFF, fpu_pkg::OP_MINMAX, 3'd0);
    send_request(32'h0000_0001, 32'h0000_0000, fpu_pkg::OP_CMP, 3'd2);
    send_request(32'h807F_FFFF, 32'h0000_0001, fpu_pkg::OP_CMP, 3'd1);
    send_request(32'h807F_FFFF, 32'h8000_0000, fpu_pkg::OP_CMP, 3'd0);
    send_request(32'h0000_0001, 32'h0000_0000, fpu_pkg::OP_CLASS, 3'd0);
    send_request(32'h807F_FFFF, 32'h0000_0000, fpu_pkg::OP_CLASS, 3'd0);
    wait_for_drain();
  endtask

  task automatic flush_to_zero_mode();
    write_ftz(1'b1);
    subnormal_cases();
    write_ftz(1'b0);
    subnormal_cases();
  endtask

  task automatic sticky_flag_accumulation();
    check_value("fflags_o", 32'(fflags_model), 32'(fflags_o));
    clear_flags();
    check_value("fflags_o", 32'd0, 32'(fflags_o));
    send_request(32'h3F80_0000, 32'h4000_0000, fpu_pkg::OP_MINMAX, 3'd1);
    wait_for_drain();
    check_value("fflags_o", 32'd0, 32'(fflags_o));
    send_request(32'h7FA0_0000, 32'h3F80_0000, fpu_pkg::OP_MINMAX, 3'd0);
    wait_for_drain();
    check_value("fflags_o", 32'd1 << fpu_pkg::STATUS_NV, 32'(fflags_o));
    clear_flags();
    check_value("fflags_o", 32'd0, 32'(fflags_o));
  endtask

  initial begin
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    in_valid_i     = 1'b0;
    op_a_i         = '0;
    op_b_i         = '0;
    op_i           = fpu_pkg::OP_SGNJ;
    variant_i      = '0;
    tag_i          = '0;
    out_ready_i    = 1'b1;
    ftz_we_i       = 1'b0;
    ftz_wdata_i    = 1'b0;
    fflags_clear_i = 1'b0;
    lfsr_state     = 32'd72;
    ftz_model      = 1'b0;
    fflags_model   = '0;
    random_ready   = 1'b0;
    next_tag       = '0;
    error_count    = 0;
    check_count    = 0;
    sent_count     = 0;
    received_count = 0;
    cycle_count    = 0;
    // Signed zeros, infinities, qNaN, sNaN, two subnormals and two normals.
    special_values = '{32'h0000_0000, 32'h8000_0000, 32'h7F80_0000, 32'hFF80_0000,
                       32'h7FC0_0000, 32'h7FA0_0000, 32'h0000_0001, 32'h807F_FFFF,
                       32'h3F80_0000, 32'hC040_0000};
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    latency_after_reset();
    special_value_sweep();
    random_traffic();
    flush_to_zero_mode();
    sticky_flag_accumulation();

    check_value("responses", sent_count, received_count);
    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+include
src/fpu_pkg.sv
src/fpu_if.sv
src/spill_register.sv
src/fpu_noncomp.sv
src/fpu_csr.sv
src/fpu_top.sv
bench/tb_fpu_top.sv

/* Makefile */
TOP = tb_fpu_top

sim:
	verilator --binary --timing -f build.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

.PHONY: sim clean
